/* build.f */
+incdir+tests
common/bus_pkg.sv
common/dispatch_pkg.sv
scheduler/cpu_scheduler.sv
memory/mem_bridge.sv
threads/thread_table.sv
logic/dispatcher_ctl.sv
logic/cpu_dispatcher.sv
tests/tb_cpu_dispatcher.sv

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // byte address seen by the CPUs and the memory
  parameter int ADDR_W = 32;

  // one memory word
  parameter int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

/* common/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

  // main controller phases
  typedef enum logic [1:0] {
    CTL_CPU_LOOP  = 2'd0,
    CTL_CPU_CMD   = 2'd1,
    CTL_MEM_WORK  = 2'd2,
    CTL_THREAD_OP = 2'd3
  } ctl_state_t;

  // messages on cpu_msg_in / cpu_msg_out
  typedef enum logic [2:0] {
    // nothing to say
    CPU_R_NULL      = 3'd0,
    // cpu took its slot
    CPU_R_START     = 3'd1,
    // cpu gave its slot back
    CPU_R_END       = 3'd2,
    // register a new thread entry address
    CPU_R_FORK_THRD = 3'd3,
    // remove a thread entry address
    CPU_R_STOP_THRD = 3'd4,
    // replies from the dispatcher
    CPU_R_FORK_DONE = 3'd5,
    CPU_R_STOP_DONE = 3'd6
  } cpu_msg_t;

  // controller to thread table
  typedef enum logic [1:0] {
    THREAD_CMD_NULL = 2'd0,
    THREAD_CMD_RUN  = 2'd1,
    THREAD_CMD_STOP = 2'd2
  } thrd_cmd_t;

  // slot index meaning table full or no match
  parameter bus_pkg::data_t THREAD_NONE = '1;

endpackage

`default_nettype wire

/* logic/cpu_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatcher #(
  parameter int CPU_QUANTITY = 4,
  parameter int THREAD_SLOTS = 4
) (
  input  logic                               clk,
  input  logic                               ext_rst_e,
  input  logic                               read_q,
  input  logic                               write_q,
  input  bus_pkg::addr_t                     addr_in,
  input  bus_pkg::data_t                     data_in,
  input  logic                               ext_cpu_e,
  input  dispatch_pkg::cpu_msg_t             cpu_msg_in,
  output logic [bit_count(CPU_QUANTITY)-1:0] ext_cpu_index,
  output logic                               ext_cpu_new,
  output logic                               ext_cpu_q,
  output bus_pkg::addr_t                     addr_out,
  output bus_pkg::data_t                     data_out,
  output logic                               read_dn,
  output logic                               write_dn,
  output dispatch_pkg::cpu_msg_t             cpu_msg_out,
  output bus_pkg::addr_t                     wb_adr,
  output bus_pkg::data_t                     wb_dat_w,
  output logic                               wb_we,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  input  bus_pkg::data_t                     wb_dat_r,
  input  logic                               wb_ack
);

  import bus_pkg::*;
  import dispatch_pkg::*;

  function automatic int bit_count(input int values);
    int bits;
    bits = 1;
    while ((1 << bits) < values) begin
      bits++;
    end
    return bits;
  endfunction

  localparam int IDX_W = bit_count(CPU_QUANTITY);

  // scheduler handshake
  logic [IDX_W-1:0] cpu_index;
  logic             cpu_new;
  logic             poll_step;
  logic             cpu_started;
  logic             cpu_ended;
  // memory request and result
  logic             mem_start;
  logic             mem_we;
  logic             mem_done;
  addr_t            mem_addr;
  data_t            mem_wdata;
  data_t            mem_rdata;
  // thread table
  thrd_cmd_t        thrd_cmd;
  addr_t            thrd_addr;
  logic             next_thread;
  addr_t            next_proc;
  data_t            slot_result;

  // port names match the nets above one to one
  dispatcher_ctl #(.CPU_QUANTITY(CPU_QUANTITY)) u_dispatcher_ctl (.*);

  cpu_scheduler #(.CPU_QUANTITY(CPU_QUANTITY)) u_cpu_scheduler (.*);

  mem_bridge u_mem_bridge (.*);

  thread_table #(.THREAD_SLOTS(THREAD_SLOTS)) u_thread_table (.*);

endmodule

`default_nettype wire

/* logic/dispatcher_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatcher_ctl #(
  parameter int CPU_QUANTITY = 4
) (
  input  logic                               clk,
  input  logic                               ext_rst_e,
  input  logic                               read_q,
  input  logic                               write_q,
  input  bus_pkg::addr_t                     addr_in,
  input  bus_pkg::data_t                     data_in,
  input  logic                               ext_cpu_e,
  input  dispatch_pkg::cpu_msg_t             cpu_msg_in,
  input  logic [bit_count(CPU_QUANTITY)-1:0] cpu_index,
  input  logic                               cpu_new,
  input  logic                               mem_done,
  input  bus_pkg::data_t                     mem_rdata,
  input  bus_pkg::addr_t                     next_proc,
  input  bus_pkg::data_t                     slot_result,
  output logic [bit_count(CPU_QUANTITY)-1:0] ext_cpu_index,
  output logic                               ext_cpu_new,
  output logic                               ext_cpu_q,
  output bus_pkg::addr_t                     addr_out,
  output bus_pkg::data_t                     data_out,
  output logic                               read_dn,
  output logic                               write_dn,
  output dispatch_pkg::cpu_msg_t             cpu_msg_out,
  output logic                               poll_step,
  output logic                               cpu_started,
  output logic                               cpu_ended,
  output logic                               mem_start,
  output logic                               mem_we,
  output bus_pkg::addr_t                     mem_addr,
  output bus_pkg::data_t                     mem_wdata,
  output dispatch_pkg::thrd_cmd_t            thrd_cmd,
  output bus_pkg::addr_t                     thrd_addr,
  output logic                               next_thread
);

  import bus_pkg::*;
  import dispatch_pkg::*;

  function automatic int bit_count(input int values);
    int bits;
    bits = 1;
    while ((1 << bits) < values) begin
      bits++;
    end
    return bits;
  endfunction

  ctl_state_t state;
  addr_t      poll_addr;
  data_t      reply_data;
  logic       cmd_msg;
  logic       mem_fin;

  // a message counts only when no memory request competes with it
  assign cmd_msg     = (state == CTL_CPU_CMD) && !read_q && !write_q && ext_cpu_e;
  assign cpu_started = cmd_msg && (cpu_msg_in == CPU_R_START);
  assign cpu_ended   = cmd_msg && (cpu_msg_in == CPU_R_END);
  // scheduler advances once per loop cycle
  assign poll_step   = (state == CTL_CPU_LOOP);

  // done window is the cycle mem_done is high
  assign mem_fin  = (state == CTL_MEM_WORK) && mem_done;
  assign read_dn  = mem_fin && !mem_we;
  assign write_dn = mem_fin && mem_we;

  // zero outside the poll and done windows
  assign addr_out = ext_cpu_q ? poll_addr : (mem_fin ? mem_addr : '0);
  assign data_out = mem_fin ? (mem_we ? '0 : mem_rdata) : reply_data;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= CTL_CPU_LOOP;
      ext_cpu_q     <= 1'b0;
      ext_cpu_index <= '0;
      ext_cpu_new   <= 1'b0;
      mem_start     <= 1'b0;
      thrd_cmd      <= THREAD_CMD_NULL;
      cpu_msg_out   <= CPU_R_NULL;
      reply_data    <= '0;
      next_thread   <= 1'b0;
    end else begin
      // single cycle strobes
      ext_cpu_q <= 1'b0;
      mem_start <= 1'b0;
      case (state)
        CTL_CPU_LOOP: begin
          ext_cpu_q     <= 1'b1;
          ext_cpu_index <= cpu_index;
          ext_cpu_new   <= cpu_new;
          state         <= CTL_CPU_CMD;
        end
        CTL_CPU_CMD: begin
          // read wins over write, memory over messages
          if (read_q || write_q) begin
            mem_start <= 1'b1;
            state     <= CTL_MEM_WORK;
          end else if (ext_cpu_e) begin
            case (cpu_msg_in)
              CPU_R_START, CPU_R_END: state <= CTL_CPU_LOOP;
              CPU_R_FORK_THRD: begin
                thrd_cmd <= THREAD_CMD_RUN;
                state    <= CTL_THREAD_OP;
              end
              CPU_R_STOP_THRD: begin
                thrd_cmd <= THREAD_CMD_STOP;
                state    <= CTL_THREAD_OP;
              end
              // replies or null coming back in are ignored
              default: state <= CTL_CPU_CMD;
            endcase
          end
        end
        CTL_MEM_WORK: begin
          if (mem_done) begin
            state <= CTL_CPU_LOOP;
          end
        end
        CTL_THREAD_OP: begin
          // first cycle the table acts, second cycle the reply is shown
          if (thrd_cmd != THREAD_CMD_NULL) begin
            thrd_cmd    <= THREAD_CMD_NULL;
            reply_data  <= slot_result;
            cpu_msg_out <= (thrd_cmd == THREAD_CMD_RUN) ? CPU_R_FORK_DONE : CPU_R_STOP_DONE;
            next_thread <= (thrd_cmd == THREAD_CMD_RUN);
          end else begin
            cpu_msg_out <= CPU_R_NULL;
            reply_data  <= '0;
            next_thread <= 1'b0;
            state       <= CTL_CPU_LOOP;
          end
        end
        default: state <= CTL_CPU_LOOP;
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state == CTL_CPU_LOOP) begin
      poll_addr <= next_proc;
    end
    if ((state == CTL_CPU_CMD) && (read_q || write_q)) begin
      mem_addr <= addr_in;
      mem_we   <= !read_q;
      if (!read_q) begin
        mem_wdata <= data_in;
      end
    end
    if (cmd_msg) begin
      thrd_addr <= addr_in;
    end
  end

  // every poll is followed by at least one command cycle
  a_poll_single : assert property (
    @(posedge clk) disable iff (ext_rst_e)
    ext_cpu_q |=> !ext_cpu_q
  );

endmodule

`default_nettype wire

/* memory/mem_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
  input  logic           clk,
  input  logic           ext_rst_e,
  input  logic           mem_start,
  input  logic           mem_we,
  input  bus_pkg::addr_t mem_addr,
  input  bus_pkg::data_t mem_wdata,
  output logic           mem_done,
  output bus_pkg::data_t mem_rdata,
  output bus_pkg::addr_t wb_adr,
  output bus_pkg::data_t wb_dat_w,
  output logic           wb_we,
  output logic           wb_cyc,
  output logic           wb_stb,
  input  bus_pkg::data_t wb_dat_r,
  input  logic           wb_ack
);

  // bus cycle control
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (wb_cyc) begin
        // slave holds us off simply by keeping ack low
        if (wb_ack) begin
          wb_cyc   <= 1'b0;
          wb_stb   <= 1'b0;
          mem_done <= 1'b1;
        end
      end else if (mem_start) begin
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
      end
    end
  end

  // address, write data and direction frozen for the whole cycle
  always_ff @(posedge clk) begin
    if (mem_start && !wb_cyc) begin
      wb_adr   <= mem_addr;
      wb_dat_w <= mem_wdata;
      wb_we    <= mem_we;
    end
  end

  // read word sampled on the acked cycle
  always_ff @(posedge clk) begin
    if (wb_cyc && wb_ack && !wb_we) begin
      mem_rdata <= wb_dat_r;
    end
  end

  a_stb_inside_cyc : assert property (
    @(posedge clk) disable iff (ext_rst_e)
    wb_stb |-> wb_cyc
  );

endmodule

`default_nettype wire

/* scheduler/cpu_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_scheduler #(
  parameter int CPU_QUANTITY = 4
) (
  input  logic                                clk,
  input  logic                                ext_rst_e,
  input  logic                                poll_step,
  input  logic                                cpu_started,
  input  logic                                cpu_ended,
  output logic [bit_count(CPU_QUANTITY)-1:0]  cpu_index,
  output logic                                cpu_new
);

  // bits needed to hold the values 0 .. values-1
  function automatic int bit_count(input int values);
    int bits;
    bits = 1;
    while ((1 << bits) < values) begin
      bits++;
    end
    return bits;
  endfunction

  localparam int IDX_W = bit_count(CPU_QUANTITY);
  // counts run from 0 up to CPU_QUANTITY inclusive
  localparam int CNT_W = bit_count(CPU_QUANTITY + 1);

  logic [CNT_W-1:0] active;
  logic [CNT_W-1:0] idle;
  logic [IDX_W-1:0] rr_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             offered;
  logic             wrap;

  // choice for the current poll, taken by the controller when poll_step is high
  always_comb begin
    // an end message may leave rr_idx past the last active cpu
    sel_idx = (CNT_W'(rr_idx) < active) ? rr_idx : '0;
    wrap    = (CNT_W'(sel_idx) + CNT_W'(1)) >= active;
    // a new slot every other poll while idle cpus remain
    cpu_new = ((idle != '0) && !offered) || (active == '0);
    cpu_index = cpu_new ? '0 : sel_idx;
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      active  <= '0;
      idle    <= CNT_W'(CPU_QUANTITY);
      rr_idx  <= '0;
      offered <= 1'b0;
    end else begin
      // start and end never arrive together
      if (cpu_started && (idle != '0)) begin
        active <= active + 1'b1;
        idle   <= idle - 1'b1;
      end else if (cpu_ended && (active != '0)) begin
        active <= active - 1'b1;
        idle   <= idle + 1'b1;
      end

      if (poll_step) begin
        offered <= cpu_new;
        // round robin over 0 .. active-1
        if (!cpu_new) begin
          rr_idx <= wrap ? '0 : sel_idx + 1'b1;
        end
      end
    end
  end

  // slots are only moved between the two counts, never lost
  a_cpu_count_total : assert property (
    @(posedge clk) disable iff (ext_rst_e)
    ({1'b0, active} + {1'b0, idle}) == (CNT_W + 1)'(CPU_QUANTITY)
  );

endmodule

`default_nettype wire

/* tests/dispatcher_tasks.svh */
`ifndef DISPATCHER_TASKS_SVH
`define DISPATCHER_TASKS_SVH

// fibonacci lfsr, taps 8 6 5 4
logic [7:0] lfsr_state = 8'd25;

// one lfsr step per bit taken
function automatic int random_bits(input int count);
  int   value;
  logic fb;
  value = 0;
  for (int i = 0; i < count; i++) begin
    value      = (value << 1) | lfsr_state[0];
    fb         = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[4];
    lfsr_state = {fb, lfsr_state[7:1]};
  end
  return value;
endfunction

// power-up memory contents, distinct for every word
function automatic data_t fill_word(input int idx);
  return {8'h5a, 4'(idx), 12'h000, 4'(~idx), 4'(idx)};
endfunction

// entry addresses used for forks
function automatic addr_t thread_addr(input int i);
  return addr_t'(32'h1000 + i * 32'h100);
endfunction

task automatic check_msg(input string what, input cpu_msg_t exp, input cpu_msg_t act);
  if (act !== exp) begin
    value_errors++;
    $display("error %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
  end
endtask

task automatic check_data(input string what, input data_t exp, input data_t act);
  if (act !== exp) begin
    value_errors++;
    $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
  if (act !== exp) begin
    value_errors++;
    $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    value_errors++;
    $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
  end
endtask

// sampled mid cycle, watchdog covers a missing poll
task automatic wait_poll();
  @(negedge clk);
  while (ext_cpu_q !== 1'b1) begin
    @(negedge clk);
  end
endtask

task automatic poll_sched(input logic exp_new, input int exp_idx);
  wait_poll();
  check_bit("ext_cpu_new", exp_new, ext_cpu_new);
  check_data("ext_cpu_index", data_t'(exp_idx), data_t'(ext_cpu_index));
endtask

task automatic poll_proc(input addr_t exp_addr);
  wait_poll();
  check_addr("poll addr_out", exp_addr, addr_out);
endtask

// one cycle message, driven on the rising edge
task automatic send_msg(input cpu_msg_t msg, input addr_t addr);
  @(posedge clk);
  ext_cpu_e  <= 1'b1;
  cpu_msg_in <= msg;
  addr_in    <= addr;
  @(posedge clk);
  ext_cpu_e  <= 1'b0;
  cpu_msg_in <= CPU_R_NULL;
  addr_in    <= '0;
endtask

task automatic mem_access(input logic we, input addr_t addr, input data_t wdata,
                          input data_t exp_rdata);
  @(posedge clk);
  read_q  <= !we;
  write_q <= we;
  addr_in <= addr;
  data_in <= wdata;
  @(posedge clk);
  read_q  <= 1'b0;
  write_q <= 1'b0;
  addr_in <= '0;
  data_in <= '0;
  @(negedge clk);
  while (!read_dn && !write_dn) begin
    @(negedge clk);
  end
  check_bit("read_dn", !we, read_dn);
  check_bit("write_dn", we, write_dn);
  // a write reports zero data
  check_data("data_out", we ? data_t'(0) : exp_rdata, data_out);
  check_addr("addr_out", addr, addr_out);
  @(negedge clk);
  if (read_dn || write_dn) begin
    other_errors++;
    $display("done pulse lasted more than one cycle in %s", test_name);
  end
  check_addr("idle addr_out", '0, addr_out);
  check_data("idle data_out", '0, data_out);
endtask

task automatic thread_op(input cpu_msg_t msg, input addr_t addr, input data_t exp_slot);
  cpu_msg_t exp_reply;
  exp_reply = (msg == CPU_R_FORK_THRD) ? CPU_R_FORK_DONE : CPU_R_STOP_DONE;
  send_msg(msg, addr);
  @(negedge clk);
  while (cpu_msg_out === CPU_R_NULL) begin
    @(negedge clk);
  end
  check_msg("reply", exp_reply, cpu_msg_out);
  check_data("slot", exp_slot, data_out);
  // reply only lasts one cycle
  @(negedge clk);
  check_msg("reply end", CPU_R_NULL, cpu_msg_out);
  check_data("idle data_out", '0, data_out);
endtask

task automatic reset_first_poll();
  test_name = "reset_poll";
  poll_sched(1'b1, 0);
  // empty table
  check_addr("poll addr_out", '0, addr_out);
endtask

task automatic start_and_poll_order();
  test_name = "start_polling";
  // previous poll offered a slot, so round robin over cpu 0
  send_msg(CPU_R_START, '0);
  poll_sched(1'b0, 0);
  send_msg(CPU_R_START, '0);
  // new slot on even polls, round robin 0 1 0 on odd ones
  for (int i = 0; i < 6; i++) begin
    if (i > 0) begin
      mem_access(1'b0, addr_t'(i * 4), '0, fill_word(i));
    end
    poll_sched(i % 2 == 0, (i % 2 == 0) ? 0 : (i / 2) % 2);
  end
endtask

task automatic mem_write_read();
  test_name = "memory";
  mem_access(1'b1, 32'h0000_0024, 32'hcafe_f00d, '0);
  wait_poll();
  mem_access(1'b0, 32'h0000_0024, '0, 32'hcafe_f00d);
  wait_poll();
endtask

task automatic fork_threads();
  test_name = "fork";
  // each new slot is the next valid one after the pointer
  for (int i = 0; i < 4; i++) begin
    thread_op(CPU_R_FORK_THRD, thread_addr(i), data_t'(i));
    poll_proc(thread_addr(i));
  end
  // table full, pointer still wraps on the done pulse
  thread_op(CPU_R_FORK_THRD, 32'h0000_0f00, THREAD_NONE);
  poll_proc(thread_addr(0));
  send_msg(CPU_R_START, '0);
  poll_proc(thread_addr(1));
  send_msg(CPU_R_START, '0);
  poll_proc(thread_addr(2));
endtask

task automatic stop_threads();
  int slot;
  test_name = "stop";
  thread_op(CPU_R_STOP_THRD, thread_addr(1), data_t'(1));
  poll_proc(thread_addr(2));
  thread_op(CPU_R_STOP_THRD, 32'h0000_0bad, THREAD_NONE);
  poll_proc(thread_addr(2));
  // end keeps the pointer, start steps it and skips slot 1
  slot = 2;
  for (int i = 0; i < 3; i++) begin
    send_msg(CPU_R_END, '0);
    poll_proc(thread_addr(slot));
    slot = (slot + 1) % 4;
    if (slot == 1) begin
      slot = 2;
    end
    send_msg(CPU_R_START, '0);
    poll_proc(thread_addr(slot));
  end
endtask

task automatic end_cpus();
  test_name = "end";
  for (int i = 0; i < 4; i++) begin
    send_msg(CPU_R_END, '0);
    if (i < 3) begin
      wait_poll();
    end
  end
  // no active cpu left, every poll offers slot 0
  poll_sched(1'b1, 0);
  for (int i = 0; i < 3; i++) begin
    mem_access(1'b0, addr_t'(32'h30 + i * 4), '0, fill_word(12 + i));
    poll_sched(1'b1, 0);
  end
endtask

`endif

/* tests/tb_cpu_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dispatcher;

  import bus_pkg::*;
  import dispatch_pkg::*;

  localparam int CPU_QUANTITY = 4;
  localparam int THREAD_SLOTS = 4;
  // directed tests need about 250 cycles, generous margin on top
  localparam int CYCLE_LIMIT = 2000;

  logic                            clk;
  logic                            ext_rst_e;
  // cpu side
  logic                            read_q;
  logic                            write_q;
  addr_t                           addr_in;
  data_t                           data_in;
  logic                            ext_cpu_e;
  cpu_msg_t                        cpu_msg_in;
  logic [$clog2(CPU_QUANTITY)-1:0] ext_cpu_index;
  logic                            ext_cpu_new;
  logic                            ext_cpu_q;
  addr_t                           addr_out;
  data_t                           data_out;
  logic                            read_dn;
  logic                            write_dn;
  cpu_msg_t                        cpu_msg_out;
  // wishbone side
  addr_t                           wb_adr;
  data_t                           wb_dat_w;
  logic                            wb_we;
  logic                            wb_cyc;
  logic                            wb_stb;
  data_t                           wb_dat_r;
  logic                            wb_ack;

  // memory model state
  data_t mem [16];
  logic  mem_busy;
  int    wait_left;
  addr_t held_adr;
  data_t held_dat;
  logic  held_we;

  int    value_errors;
  int    other_errors;
  int    cycle_count;
  string test_name;

  cpu_dispatcher #(
    .CPU_QUANTITY(CPU_QUANTITY),
    .THREAD_SLOTS(THREAD_SLOTS)
  ) u_cpu_dispatcher (.*);

  `include "dispatcher_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // wishbone slave, registered ack after a random wait
  always @(posedge clk) begin
    if (ext_rst_e) begin
      wb_ack   <= 1'b0;
      mem_busy <= 1'b0;
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;
      mem_busy <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!mem_busy) begin
        // new cycle, 0 to 3 wait cycles
        mem_busy  <= 1'b1;
        wait_left <= random_bits(2);
        held_adr  <= wb_adr;
        held_dat  <= wb_dat_w;
        held_we   <= wb_we;
      end else begin
        if ((wb_adr !== held_adr) || (wb_dat_w !== held_dat) || (wb_we !== held_we)) begin
          other_errors++;
          $display("wishbone address, data or direction changed during a cycle in %s",
                   test_name);
        end
        if (wait_left == 0) begin
          wb_ack <= 1'b1;
          if (wb_we) begin
            mem[wb_adr[5:2]] <= wb_dat_w;
          end else begin
            wb_dat_r <= mem[wb_adr[5:2]];
          end
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    value_errors = 0;
    other_errors = 0;
    test_name    = "init";
    ext_rst_e    = 1'b1;
    read_q       = 1'b0;
    write_q      = 1'b0;
    addr_in      = '0;
    data_in      = '0;
    ext_cpu_e    = 1'b0;
    cpu_msg_in   = CPU_R_NULL;
    wb_dat_r     = '0;
    wb_ack       = 1'b0;
    mem_busy     = 1'b0;
    wait_left    = 0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk);
    ext_rst_e <= 1'b0;

    reset_first_poll();
    start_and_poll_order();
    mem_write_read();
    fork_threads();
    stop_threads();
    end_cpus();

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* threads/thread_table.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_table #(
  parameter int THREAD_SLOTS = 4
) (
  input  logic                    clk,
  input  logic                    ext_rst_e,
  input  dispatch_pkg::thrd_cmd_t thrd_cmd,
  input  bus_pkg::addr_t          thrd_addr,
  input  logic                    next_thread,
  input  logic                    cpu_started,
  output bus_pkg::addr_t          next_proc,
  output bus_pkg::data_t          slot_result
);

  import bus_pkg::*;
  import dispatch_pkg::*;

  localparam int SLOT_W = (THREAD_SLOTS > 1) ? $clog2(THREAD_SLOTS) : 1;

  addr_t             slot_addr [THREAD_SLOTS];
  logic [THREAD_SLOTS-1:0] slot_valid;
  logic [SLOT_W-1:0] ptr;
  logic [SLOT_W-1:0] ptr_next;
  logic [SLOT_W-1:0] free_idx;
  logic [SLOT_W-1:0] hit_idx;
  logic              free_found;
  logic              hit_found;
  logic              fork_ok;
  logic              stop_ok;

  // lowest free slot and lowest slot holding thrd_addr
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    hit_found  = 1'b0;
    hit_idx    = '0;
    // scan downwards so the lowest index wins
    for (int i = THREAD_SLOTS - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_found = 1'b1;
        free_idx   = SLOT_W'(i);
      end
      if (slot_valid[i] && (slot_addr[i] == thrd_addr)) begin
        hit_found = 1'b1;
        hit_idx   = SLOT_W'(i);
      end
    end
  end

  // first valid slot after ptr, wrapping; ptr itself is the last candidate
  always_comb begin
    int idx;
    ptr_next = ptr;
    for (int k = THREAD_SLOTS; k >= 1; k--) begin
      idx = (int'(ptr) + k) % THREAD_SLOTS;
      if (slot_valid[idx]) begin
        ptr_next = SLOT_W'(idx);
      end
    end
  end

  assign fork_ok = (thrd_cmd == THREAD_CMD_RUN) && free_found;
  assign stop_ok = (thrd_cmd == THREAD_CMD_STOP) && hit_found;

  // slot index reported back while the command is presented
  always_comb begin
    slot_result = THREAD_NONE;
    if (fork_ok) begin
      slot_result = data_t'(free_idx);
    end else if (stop_ok) begin
      slot_result = data_t'(hit_idx);
    end
  end

  // empty table reads as address 0
  assign next_proc = slot_valid[ptr] ? slot_addr[ptr] : '0;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      slot_valid <= '0;
      ptr        <= '0;
    end else begin
      if (fork_ok) begin
        slot_valid[free_idx] <= 1'b1;
      end
      if (stop_ok) begin
        slot_valid[hit_idx] <= 1'b0;
      end
      // also step off a slot that is being stopped under the pointer
      if (next_thread || cpu_started || (stop_ok && (hit_idx == ptr))) begin
        ptr <= ptr_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fork_ok) begin
      slot_addr[free_idx] <= thrd_addr;
    end
  end

endmodule

`default_nettype wire
